// ==== ksk_rd_pkg.sv ====
/* Widths, key geometry, command, AXI and key-RAM write types,
   and the AXI data-word union of the KSK loader */
package ksk_rd_pkg;

  // ------------------------------
  // AXI4
  // ------------------------------
  localparam int         AXI4_ADD_W        = 32;
  localparam int         AXI4_DATA_W       = 64;
  localparam int         AXI4_DATA_BYTES   = AXI4_DATA_W / 8;
  localparam int         AXI4_DATA_BYTES_W = $clog2(AXI4_DATA_BYTES);
  localparam int         AXI4_ID_W         = 2;
  localparam logic [1:0] AXI4B_INCR        = 2'b01;

  // ------------------------------
  // Key geometry
  // ------------------------------
  localparam int KSK_ACS_W          = 16;
  localparam int COEF_PER_WORD      = AXI4_DATA_W / KSK_ACS_W;
  localparam int CUT_FCOEF_NB       = 2;
  localparam int BLOCK_PER_WORD     = COEF_PER_WORD / CUT_FCOEF_NB;
  localparam int BCOL_BLOCK_NB      = 5;
  localparam int WORD_PER_BCOL      = (BCOL_BLOCK_NB + BLOCK_PER_WORD - 1) / BLOCK_PER_WORD;
  // Last word of a column is only partly filled
  localparam int LAST_WORD_BLOCK_NB = BCOL_BLOCK_NB - (WORD_PER_BCOL - 1) * BLOCK_PER_WORD;

  localparam int LBX             = 4;
  localparam int LBX_W           = 2;
  // Key length 14 leaves 2 columns in the last block-column
  localparam int LAST_LBX        = 2;
  localparam int KS_BLOCK_COL_NB = 4;
  localparam int KS_BLOCK_COL_W  = 2;

  localparam int KSK_SLOT_NB    = 4;
  localparam int KSK_SLOT_W     = 2;
  localparam int KSK_SLOT_DEPTH = LBX * BCOL_BLOCK_NB;
  localparam int KSK_RAM_ADD_W  = $clog2(KSK_SLOT_NB * KSK_SLOT_DEPTH);
  localparam int SLOT_BYTES     = LBX * WORD_PER_BCOL * AXI4_DATA_BYTES;

  // ------------------------------
  // Types
  // ------------------------------
  typedef struct packed {
    logic [KSK_SLOT_W-1:0]     slot_id;
    logic [KS_BLOCK_COL_W-1:0] ks_loop;
  } ksk_read_cmd_t;

  typedef struct packed {
    logic [AXI4_ID_W-1:0]  arid;
    logic [AXI4_ADD_W-1:0] araddr;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    logic [1:0]            arburst;
  } axi4_ar_t;

  typedef struct packed {
    logic [AXI4_ID_W-1:0]   rid;
    logic [AXI4_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rlast;
  } axi4_r_t;

  typedef logic [CUT_FCOEF_NB-1:0][KSK_ACS_W-1:0] ksk_block_t;

  // One AXI word, seen as raw bits or as coefficient blocks
  typedef union packed {
    logic [AXI4_DATA_W-1:0]          raw;
    ksk_block_t [BLOCK_PER_WORD-1:0] blk;
  } ksk_word_u;

  typedef struct packed {
    ksk_block_t                data;
    logic [KSK_RAM_ADD_W-1:0]  add;
    logic [LBX_W-1:0]          x_idx;
    logic [KSK_SLOT_W-1:0]     slot;
    logic [KS_BLOCK_COL_W-1:0] ks_loop;
  } ksk_wr_t;

  // Index of the last column in a block-column
  function automatic logic [LBX_W-1:0] bcol_x_max(input logic [KS_BLOCK_COL_W-1:0] ks_loop);
    return (ks_loop == KS_BLOCK_COL_W'(KS_BLOCK_COL_NB - 1)) ? LBX_W'(LAST_LBX - 1)
                                                            : LBX_W'(LBX - 1);
  endfunction

endpackage

// ==== ksk_rd_fifo.sv ====
/* Circular register FIFO with valid/ready on both sides */
module ksk_rd_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_vld,
  output logic             in_rdy,

  output logic [WIDTH-1:0] out_data,
  output logic             out_vld,
  input  logic             out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_rdy   = (count != CNT_W'(DEPTH));
  assign out_vld  = (count != '0);
  assign out_data = mem[rd_ptr];
  assign push     = in_vld & in_rdy;
  assign pop      = out_vld & out_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  // A write never lands on an entry that is still unread
  a_no_write_full: assert property (@(posedge clk) disable iff (!s_rst_n)
    push |-> (count == '0) || (wr_ptr != rd_ptr));

endmodule

// ==== ksk_rd_ar_gen.sv ====
/* AXI read burst generator. Registers the command, hands it to reception,
   then splits each block-column into page-bounded bursts */
module ksk_rd_ar_gen
  import ksk_rd_pkg::*;
#(
  parameter int PAGE_BYTES = 32,
  parameter int RECP_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic [AXI4_ADD_W-1:0] ksk_mem_addr,

  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  ksk_read_cmd_t         cmd,

  output axi4_ar_t              ar,
  output logic                  ar_valid,
  input  logic                  ar_ready,

  output logic                  recp_vld,
  input  logic                  recp_rdy,
  output ksk_read_cmd_t         recp_cmd
);

  localparam int PAGE_W = $clog2(PAGE_BYTES);
  localparam int COL_W  = $clog2(WORD_PER_BCOL + 1);

  if (PAGE_BYTES < AXI4_DATA_BYTES || (1 << PAGE_W) != PAGE_BYTES || RECP_DEPTH < 1)
  begin : g_bad_param
    $fatal(1, "PAGE_BYTES must be a power of two of at least one word, RECP_DEPTH >= 1");
  end

  ksk_read_cmd_t         cmd_q;
  logic                  busy;
  logic                  sent;
  logic [AXI4_ADD_W-1:0] add_q;
  logic [COL_W-1:0]      col_remain;
  logic [LBX_W-1:0]      x_idx;
  logic [PAGE_W:0]       page_remain;
  logic [8:0]            word_nb;
  logic                  last_col_word;
  logic                  last_x;
  axi4_ar_t              s0_ar;
  logic                  s0_send;
  axi4_ar_t              skid;
  logic                  skid_vld;
  logic                  move;

  assign recp_vld = busy & ~sent;
  assign recp_cmd = cmd_q;

  // Burst length is bounded by the page end and the column end
  assign page_remain   = ((PAGE_W + 1)'(PAGE_BYTES) - (PAGE_W + 1)'(add_q[PAGE_W-1:0]))
                         >> AXI4_DATA_BYTES_W;
  assign word_nb       = (32'(page_remain) < 32'(col_remain)) ? 9'(page_remain)
                                                              : 9'(col_remain);
  assign last_col_word = (9'(col_remain) == word_nb);
  assign last_x        = (x_idx == bcol_x_max(cmd_q.ks_loop));

  assign s0_ar.arid    = '0;
  assign s0_ar.araddr  = add_q;
  assign s0_ar.arlen   = 8'(word_nb - 9'd1);
  assign s0_ar.arsize  = 3'(AXI4_DATA_BYTES_W);
  assign s0_ar.arburst = AXI4B_INCR;

  assign s0_send = busy & sent & ~skid_vld;
  assign cmd_rdy = s0_send & last_col_word & last_x;
  assign move    = ~ar_valid | ar_ready;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      busy       <= 1'b0;
      sent       <= 1'b0;
      col_remain <= COL_W'(WORD_PER_BCOL);
      x_idx      <= '0;
      ar_valid   <= 1'b0;
      skid_vld   <= 1'b0;
    end else begin
      if (cmd_rdy)      busy <= 1'b0;
      else if (cmd_vld) busy <= 1'b1;
      if (cmd_rdy)                   sent <= 1'b0;
      else if (recp_vld && recp_rdy) sent <= 1'b1;
      if (s0_send) begin
        col_remain <= last_col_word ? COL_W'(WORD_PER_BCOL) : col_remain - COL_W'(word_nb);
        if (last_col_word) x_idx <= last_x ? '0 : x_idx + 1'b1;
      end
      if (move) ar_valid <= skid_vld | s0_send;
      if (move)         skid_vld <= 1'b0;
      else if (s0_send) skid_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld && !busy) cmd_q <= cmd;
    if (recp_vld && recp_rdy) begin
      add_q <= ksk_mem_addr + AXI4_ADD_W'(cmd_q.ks_loop) * AXI4_ADD_W'(SLOT_BYTES);
    end else if (s0_send) begin
      add_q <= add_q + (AXI4_ADD_W'(word_nb) << AXI4_DATA_BYTES_W);
    end
    if (move)              ar   <= skid_vld ? skid : s0_ar;
    if (!move && s0_send)  skid <= s0_ar;
  end

  a_base_aligned: assert property (@(posedge clk) disable iff (!s_rst_n)
    busy |-> (ksk_mem_addr[AXI4_DATA_BYTES_W-1:0] == '0));

  a_no_page_cross: assert property (@(posedge clk) disable iff (!s_rst_n)
    ar_valid |-> (32'(ar.araddr[PAGE_W-1:0]) + ((32'(ar.arlen) + 1) << AXI4_DATA_BYTES_W)
                  <= PAGE_BYTES));

endmodule

// ==== ksk_rd_beat_track.sv ====
/* Pairs buffered read beats with their reception command and tracks
   the word and column position of each beat */
module ksk_rd_beat_track
  import ksk_rd_pkg::*;
(
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic             r_data_vld,
  output logic             r_data_rdy,
  input  axi4_r_t          r_data,

  input  logic             recp_vld,
  output logic             recp_rdy,
  input  ksk_read_cmd_t    recp_cmd,

  output logic             beat_vld,
  input  logic             beat_rdy,
  output ksk_word_u        beat_word,
  output ksk_read_cmd_t    beat_cmd,
  output logic [LBX_W-1:0] beat_x_idx,
  output logic             beat_last_word
);

  localparam int WORD_W = (WORD_PER_BCOL > 1) ? $clog2(WORD_PER_BCOL) : 1;

  logic [WORD_W-1:0] word_cnt;
  logic [LBX_W-1:0]  x_cnt;
  logic              take;
  logic              last_x;

  assign beat_vld   = r_data_vld & recp_vld;
  assign r_data_rdy = beat_rdy & recp_vld;
  assign take       = beat_vld & beat_rdy;

  assign beat_word      = ksk_word_u'(r_data.rdata);
  assign beat_cmd       = recp_cmd;
  assign beat_x_idx     = x_cnt;
  assign beat_last_word = (word_cnt == WORD_W'(WORD_PER_BCOL - 1));
  assign last_x         = (x_cnt == bcol_x_max(recp_cmd.ks_loop));

  // Command leaves reception with its final beat
  assign recp_rdy = take & beat_last_word & last_x;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      word_cnt <= '0;
      x_cnt    <= '0;
    end else if (take) begin
      word_cnt <= beat_last_word ? '0 : word_cnt + 1'b1;
      if (beat_last_word) x_cnt <= last_x ? '0 : x_cnt + 1'b1;
    end
  end

  // Bursts are only issued after their command entered reception
  a_beat_has_cmd: assert property (@(posedge clk) disable iff (!s_rst_n)
    r_data_vld |-> recp_vld);

endmodule

// ==== ksk_rd_unpack.sv ====
/* Slices AXI words into coefficient blocks, builds the key-RAM write
   and pulses slot_done with the final block of a command */
module ksk_rd_unpack
  import ksk_rd_pkg::*;
(
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  beat_vld,
  output logic                  beat_rdy,
  input  ksk_word_u             beat_word,
  input  ksk_read_cmd_t         beat_cmd,
  input  logic [LBX_W-1:0]      beat_x_idx,
  input  logic                  beat_last_word,

  output logic                  wr_en,
  output ksk_wr_t               wr,
  output logic                  slot_done,
  output logic [KSK_SLOT_W-1:0] slot_done_id
);

  localparam int BLOCK_W = $bits(ksk_block_t);
  localparam int PEND_W  = (BLOCK_PER_WORD > 1) ? $clog2(BLOCK_PER_WORD) : 1;
  localparam int ELT_W   = $clog2(KSK_SLOT_DEPTH);

  ksk_word_u        sr;
  logic [PEND_W-1:0] pend;
  logic [PEND_W-1:0] pend_init;
  ksk_read_cmd_t    cmd_q;
  logic [LBX_W-1:0] x_q;
  logic             last_word_q;
  logic [ELT_W-1:0] elt;

  logic             take;
  logic             emit;
  ksk_block_t       cur_blk;
  ksk_read_cmd_t    cur_cmd;
  logic [LBX_W-1:0] cur_x;
  logic             cur_last_word;
  logic             last_in_word;
  logic             cmd_end;

  // New word only once the previous one is fully out
  assign beat_rdy = (pend == '0);
  assign take     = beat_vld & beat_rdy;
  assign emit     = take | (pend != '0);

  // First block goes straight out on load
  assign cur_blk       = take ? beat_word.blk[0] : sr.blk[0];
  assign cur_cmd       = take ? beat_cmd         : cmd_q;
  assign cur_x         = take ? beat_x_idx       : x_q;
  assign cur_last_word = take ? beat_last_word   : last_word_q;

  // Blocks still held after the first one
  assign pend_init = beat_last_word ? PEND_W'(LAST_WORD_BLOCK_NB - 1)
                                    : PEND_W'(BLOCK_PER_WORD - 1);

  assign last_in_word = take ? (pend_init == '0) : (pend == PEND_W'(1));
  assign cmd_end      = emit & last_in_word & cur_last_word
                        & (cur_x == bcol_x_max(cur_cmd.ks_loop));

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pend      <= '0;
      elt       <= '0;
      wr_en     <= 1'b0;
      slot_done <= 1'b0;
    end else begin
      if (take)              pend <= pend_init;
      else if (pend != '0)   pend <= pend - 1'b1;
      if (emit) elt <= cmd_end ? '0 : elt + 1'b1;
      wr_en     <= emit;
      slot_done <= cmd_end;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sr.raw      <= beat_word.raw >> BLOCK_W;
      cmd_q       <= beat_cmd;
      x_q         <= beat_x_idx;
      last_word_q <= beat_last_word;
    end else if (emit) begin
      sr.raw <= sr.raw >> BLOCK_W;
    end
    if (emit) begin
      wr.data    <= cur_blk;
      wr.add     <= KSK_RAM_ADD_W'(cur_cmd.slot_id) * KSK_RAM_ADD_W'(KSK_SLOT_DEPTH)
                    + KSK_RAM_ADD_W'(elt);
      wr.x_idx   <= cur_x;
      wr.slot    <= cur_cmd.slot_id;
      wr.ks_loop <= cur_cmd.ks_loop;
    end
    if (cmd_end) slot_done_id <= cur_cmd.slot_id;
  end

endmodule

// ==== ksk_rd_top.sv ====
/* KSK loader top level. Burst generator, reception and read-data FIFOs,
   beat tracking and block unpacking */
module ksk_rd_top
  import ksk_rd_pkg::*;
#(
  parameter int PAGE_BYTES = 32,
  parameter int RECP_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic [AXI4_ADD_W-1:0] ksk_mem_addr,

  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  ksk_read_cmd_t         cmd,

  output axi4_ar_t              ar,
  output logic                  ar_valid,
  input  logic                  ar_ready,
  input  axi4_r_t               r,
  input  logic                  r_valid,
  output logic                  r_ready,

  output logic                  wr_en,
  output ksk_wr_t               wr,
  output logic                  slot_done,
  output logic [KSK_SLOT_W-1:0] slot_done_id
);

  logic             recp_in_vld;
  logic             recp_in_rdy;
  ksk_read_cmd_t    recp_in_cmd;
  logic             recp_out_vld;
  logic             recp_out_rdy;
  ksk_read_cmd_t    recp_out_cmd;
  axi4_r_t          r_buf;
  logic             r_buf_vld;
  logic             r_buf_rdy;
  logic             beat_vld;
  logic             beat_rdy;
  ksk_word_u        beat_word;
  ksk_read_cmd_t    beat_cmd;
  logic [LBX_W-1:0] beat_x_idx;
  logic             beat_last_word;

  ksk_rd_ar_gen #(.PAGE_BYTES(PAGE_BYTES), .RECP_DEPTH(RECP_DEPTH)) ar_gen (
    .clk(clk), .s_rst_n(s_rst_n), .ksk_mem_addr(ksk_mem_addr),
    .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy), .cmd(cmd),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .recp_vld(recp_in_vld), .recp_rdy(recp_in_rdy), .recp_cmd(recp_in_cmd)
  );

  // Commands waiting for their data
  ksk_rd_fifo #(.WIDTH($bits(ksk_read_cmd_t)), .DEPTH(RECP_DEPTH)) recp_fifo (
    .clk(clk), .s_rst_n(s_rst_n),
    .in_data(recp_in_cmd), .in_vld(recp_in_vld), .in_rdy(recp_in_rdy),
    .out_data(recp_out_cmd), .out_vld(recp_out_vld), .out_rdy(recp_out_rdy)
  );

  ksk_rd_fifo #(.WIDTH($bits(axi4_r_t)), .DEPTH(2)) r_fifo (
    .clk(clk), .s_rst_n(s_rst_n),
    .in_data(r), .in_vld(r_valid), .in_rdy(r_ready),
    .out_data(r_buf), .out_vld(r_buf_vld), .out_rdy(r_buf_rdy)
  );

  ksk_rd_beat_track beat_track (
    .clk(clk), .s_rst_n(s_rst_n),
    .r_data_vld(r_buf_vld), .r_data_rdy(r_buf_rdy), .r_data(r_buf),
    .recp_vld(recp_out_vld), .recp_rdy(recp_out_rdy), .recp_cmd(recp_out_cmd),
    .beat_vld(beat_vld), .beat_rdy(beat_rdy), .beat_word(beat_word),
    .beat_cmd(beat_cmd), .beat_x_idx(beat_x_idx), .beat_last_word(beat_last_word)
  );

  ksk_rd_unpack unpack (
    .clk(clk), .s_rst_n(s_rst_n),
    .beat_vld(beat_vld), .beat_rdy(beat_rdy), .beat_word(beat_word),
    .beat_cmd(beat_cmd), .beat_x_idx(beat_x_idx), .beat_last_word(beat_last_word),
    .wr_en(wr_en), .wr(wr), .slot_done(slot_done), .slot_done_id(slot_done_id)
  );

endmodule

// ==== tb_ksk_rd_vectors.svh ====
/* Command table with expected write counts, and reference models
   for memory contents, burst lists and key-RAM writes */
`ifndef TB_KSK_RD_VECTORS_SVH
`define TB_KSK_RD_VECTORS_SVH

// ------------------------------
// Command table
// ------------------------------
localparam int CMD_NB     = 8;
localparam int BASE_ADDR  = 'h1010;
localparam int PAGE       = 32;
localparam int COL_WORDS  = 3;
localparam int COL_BLOCKS = 5;
localparam int SLOT_DEPTH = 20;
localparam int BCOL_BYTES = 96;

// Columns are slot id, ks_loop, expected write count
int tbl_slot  [CMD_NB] = '{0, 1, 2, 3, 2, 0, 3, 1};
int tbl_ks    [CMD_NB] = '{0, 3, 1, 2, 3, 0, 1, 2};
int tbl_wr_nb [CMD_NB] = '{20, 10, 20, 20, 10, 20, 20, 20};

// ------------------------------
// Reference models
// ------------------------------
// Coefficient i of a word is addr/8*4 + i
function automatic logic [63:0] mem_word(input int addr);
  logic [63:0] w;
  for (int i = 0; i < 4; i++) begin
    w[i*16 +: 16] = 16'((addr / 8) * 4 + i);
  end
  return w;
endfunction

// Queue the bursts and key-RAM writes of one command
task automatic add_cmd_expect(input int slot, input int ks);
  int          ncol;
  int          left;
  int          n;
  int          a;
  int          col_a;
  logic [63:0] word;
  ksk_wr_t     w;
  // Key length 14 leaves 2 columns in the last block-column
  ncol = (ks == 3) ? 2 : 4;
  a    = BASE_ADDR + ks * BCOL_BYTES;
  for (int x = 0; x < ncol; x++) begin
    col_a = a;
    left  = COL_WORDS;
    // Burst ends at the page end or the column end
    while (left > 0) begin
      n = (PAGE - a % PAGE) / 8;
      if (n > left) n = left;
      exp_addr_q.push_back(a);
      exp_len_q.push_back(n - 1);
      a    = a + n * 8;
      left = left - n;
    end
    for (int b = 0; b < COL_BLOCKS; b++) begin
      word      = mem_word(col_a + (b / 2) * 8);
      w.data    = word[(b % 2) * 32 +: 32];
      w.add     = 7'(slot * SLOT_DEPTH + x * COL_BLOCKS + b);
      w.x_idx   = 2'(x);
      w.slot    = 2'(slot);
      w.ks_loop = 2'(ks);
      exp_wr_q.push_back(w);
      exp_last_q.push_back(x == ncol - 1 && b == COL_BLOCKS - 1);
    end
  end
endtask

`endif

// ==== tb_ksk_rd.sv ====
/* Testbench of the KSK loader. Clock and reset, command driver,
   AXI memory model with random stalls, burst and write checkers */
module tb_ksk_rd
  import ksk_rd_pkg::*;
();

  logic                  clk;
  logic                  s_rst_n;
  logic [AXI4_ADD_W-1:0] ksk_mem_addr;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  ksk_read_cmd_t         cmd;
  axi4_ar_t              ar;
  logic                  ar_valid;
  logic                  ar_ready;
  axi4_r_t               r;
  logic                  r_valid;
  logic                  r_ready;
  logic                  wr_en;
  ksk_wr_t               wr;
  logic                  slot_done;
  logic [KSK_SLOT_W-1:0] slot_done_id;

  int      seed       = 5116;
  int      ar_err     = 0;
  int      wr_err     = 0;
  int      done_err   = 0;
  int      done_idx   = 0;
  int      cmd_wr_cnt = 0;
  int      beat_idx   = 0;
  bit      r_taken    = 1'b0;
  int      exp_addr_q [$];
  int      exp_len_q  [$];
  ksk_wr_t exp_wr_q   [$];
  bit      exp_last_q [$];
  // Bursts accepted by the memory model and not yet answered
  int      rd_addr_q  [$];
  int      rd_len_q   [$];

  `include "tb_ksk_rd_vectors.svh"

  ksk_rd_top #(.PAGE_BYTES(32), .RECP_DEPTH(4)) UUT (
    .clk(clk), .s_rst_n(s_rst_n), .ksk_mem_addr(ksk_mem_addr),
    .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy), .cmd(cmd),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .wr_en(wr_en), .wr(wr), .slot_done(slot_done), .slot_done_id(slot_done_id)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_field(input string name, input int got, input int exp, inout int cnt);
    assert (got == exp) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      cnt++;
    end
  endtask

  task automatic report_counts();
    $display("Errors: burst=%0d write=%0d done=%0d", ar_err, wr_err, done_err);
  endtask

  // ------------------------------
  // AR channel and memory model
  // ------------------------------
  always @(posedge clk) begin : sample_ar
    if (s_rst_n && ar_valid && ar_ready) begin
      assert (exp_addr_q.size() != 0) else begin
        $display("Burst at %0t when no burst was expected", $time);
        ar_err++;
      end
      if (exp_addr_q.size() != 0) begin
        check_field("ar.araddr", int'(ar.araddr), exp_addr_q.pop_front(), ar_err);
        check_field("ar.arlen", int'(ar.arlen), exp_len_q.pop_front(), ar_err);
      end
      check_field("ar.arid", int'(ar.arid), 0, ar_err);
      check_field("ar.arsize", int'(ar.arsize), 3, ar_err);
      check_field("ar.arburst", int'(ar.arburst), 1, ar_err);
      assert (int'(ar.araddr) % PAGE + (int'(ar.arlen) + 1) * 8 <= PAGE) else begin
        $display("Burst at %0t crosses a 32-byte page", $time);
        ar_err++;
      end
      rd_addr_q.push_back(int'(ar.araddr));
      rd_len_q.push_back(int'(ar.arlen));
    end
    r_taken = r_valid && r_ready;
  end

  // Answers bursts in order, one beat held until accepted
  always @(negedge clk) begin : drive_mem
    if (!s_rst_n) begin
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      beat_idx = 0;
    end else begin
      ar_ready = (($random(seed) & 3) != 0);
      if (!r_valid || r_taken) begin
        r_valid = 1'b0;
        if (rd_addr_q.size() != 0 && ($random(seed) & 3) != 0) begin
          r.rdata = mem_word(rd_addr_q[0] + beat_idx * 8);
          r.rlast = (beat_idx == rd_len_q[0]);
          r_valid = 1'b1;
          if (r.rlast) begin
            void'(rd_addr_q.pop_front());
            void'(rd_len_q.pop_front());
            beat_idx = 0;
          end else begin
            beat_idx++;
          end
        end
      end
    end
  end

  // ------------------------------
  // Key-RAM writes and slot_done
  // ------------------------------
  always @(posedge clk) begin : check_wr
    ksk_wr_t e;
    bit      last;
    if (s_rst_n && wr_en) begin
      cmd_wr_cnt++;
      assert (exp_wr_q.size() != 0) else begin
        $display("Key-RAM write at %0t when no write was expected", $time);
        wr_err++;
      end
      if (exp_wr_q.size() != 0) begin
        e    = exp_wr_q.pop_front();
        last = exp_last_q.pop_front();
        check_field("wr.data", int'(wr.data), int'(e.data), wr_err);
        check_field("wr.add", int'(wr.add), int'(e.add), wr_err);
        check_field("wr.x_idx", int'(wr.x_idx), int'(e.x_idx), wr_err);
        check_field("wr.slot", int'(wr.slot), int'(e.slot), wr_err);
        check_field("wr.ks_loop", int'(wr.ks_loop), int'(e.ks_loop), wr_err);
        check_field("slot_done", int'(slot_done), int'(last), done_err);
      end
    end
    if (s_rst_n && slot_done) begin
      assert (wr_en && done_idx < CMD_NB) else begin
        $display("slot_done at %0t without a write or beyond the table", $time);
        done_err++;
      end
      if (done_idx < CMD_NB) begin
        check_field("slot_done_id", int'(slot_done_id), tbl_slot[done_idx], done_err);
        check_field("write count", cmd_wr_cnt, tbl_wr_nb[done_idx], done_err);
      end
      done_idx++;
      cmd_wr_cnt = 0;
    end
  end

  // ------------------------------
  // Command driver
  // ------------------------------
  initial begin : run_cmds
    s_rst_n      = 1'b0;
    cmd_vld      = 1'b0;
    cmd          = '0;
    ar_ready     = 1'b0;
    r_valid      = 1'b0;
    r            = '0;
    ksk_mem_addr = BASE_ADDR;
    repeat (8) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;
    assert (!ar_valid && !wr_en && !slot_done && !cmd_rdy) else begin
      $display("Outputs not idle after reset at %0t", $time);
      done_err++;
    end
    for (int k = 0; k < CMD_NB; k++) begin
      add_cmd_expect(tbl_slot[k], tbl_ks[k]);
      cmd.slot_id = 2'(tbl_slot[k]);
      cmd.ks_loop = 2'(tbl_ks[k]);
      cmd_vld     = 1'b1;
      @(posedge clk);
      while (!cmd_rdy) @(posedge clk);
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    wait (done_idx == CMD_NB);
    repeat (20) @(posedge clk);
    assert (exp_wr_q.size() == 0 && exp_addr_q.size() == 0) else begin
      $display("Some expected bursts or writes never appeared");
      wr_err++;
    end
    report_counts();
    if (ar_err + wr_err + done_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Each command needs well under 400 cycles even with stalls
  initial begin : watchdog
    repeat (CMD_NB * 400) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", CMD_NB * 400);
    report_counts();
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== ksk_rd.f ====
+incdir+.
ksk_rd_pkg.sv
ksk_rd_fifo.sv
ksk_rd_ar_gen.sv
ksk_rd_beat_track.sv
ksk_rd_unpack.sv
ksk_rd_top.sv
tb_ksk_rd.sv

// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert
TOP     = tb_ksk_rd
RTL_TOP = ksk_rd_top
FLIST   = ksk_rd.f
PASS    = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
